//--- design/fd_config.svh
`ifndef FD_CONFIG_SVH
`define FD_CONFIG_SVH

// ==================================================
// field widths
// ==================================================

// delivery-man id and restaurant id
`define FD_ID_W 8

// stock and order-limit counts
`define FD_SER_W 8

// input bus word
`define FD_BUS_W 16

// ==================================================
// dram word layout
// ==================================================

`define FD_WORD_W 64
`define FD_ADDR_W 8

// one customer slot, stored byte-swapped
`define FD_SLOT_W 16

// slot 2 on top, then slot 1, then the restaurant info
`define FD_SLOT2_LSB 48
`define FD_SLOT1_LSB 32
`define FD_RES_LSB 0

// foods kept per restaurant
`define FD_FOOD_CNT 3

`endif

//--- design/fd_pkg.sv
`include "fd_config.svh"

package fd_pkg;

    // ==================================================
    // encodings
    // ==================================================

    typedef enum logic [2:0] {
        ACT_NONE    = 3'd0,
        ACT_ORDER   = 3'd1,
        ACT_DELIVER = 3'd2,
        ACT_CANCEL  = 3'd3
    } action_e;

    typedef enum logic [1:0] {
        FOOD_NONE = 2'd0,
        FOOD1     = 2'd1,
        FOOD2     = 2'd2,
        FOOD3     = 2'd3
    } food_e;

    typedef enum logic [1:0] {
        ST_NONE   = 2'd0,
        ST_NORMAL = 2'd1,
        ST_VIP    = 2'd2
    } status_e;

    typedef enum logic [3:0] {
        ERR_NONE          = 4'd0,
        ERR_RES_BUSY      = 4'd1,
        ERR_NO_CUSTOMERS  = 4'd2,
        ERR_WRONG_CANCEL  = 4'd3,
        ERR_WRONG_RES_ID  = 4'd4,
        ERR_WRONG_FOOD_ID = 4'd5
    } err_e;

    // ==================================================
    // records
    // ==================================================

    typedef struct packed {
        status_e               status;
        logic [`FD_ID_W-1:0]   res_id;
        food_e                 food_id;
        logic [3:0]            ser;
    } ctm_info_t;

    // slot 2 sits in the upper half
    typedef struct packed {
        ctm_info_t ctm_info2;
        ctm_info_t ctm_info1;
    } dman_info_t;

    // stock[3] is food3, so a food id indexes it directly
    typedef struct packed {
        logic [`FD_FOOD_CNT:1][`FD_SER_W-1:0] stock;
        logic [`FD_SER_W-1:0]                 limit;
    } res_info_t;

    typedef struct packed {
        food_e      food_id;
        logic [5:0] ser;
    } food_ser_t;

    // ==================================================
    // input bus views
    // ==================================================

    typedef struct packed {
        logic [`FD_BUS_W-$bits(action_e)-1:0] rsvd;
        action_e                              act;
    } bus_act_t;

    typedef struct packed {
        logic [`FD_BUS_W-`FD_ID_W-1:0] rsvd;
        logic [`FD_ID_W-1:0]           val;
    } bus_id_t;

    typedef struct packed {
        logic [`FD_BUS_W-$bits(food_ser_t)-1:0] rsvd;
        food_ser_t                              food;
    } bus_food_t;

    typedef union packed {
        bus_act_t  act;
        bus_id_t   id;
        bus_id_t   res;
        bus_food_t food;
    } d_bus_u;

    // captured command with its operand flags
    typedef struct packed {
        action_e             act;
        logic [`FD_ID_W-1:0] id;
        logic [`FD_ID_W-1:0] res;
        food_ser_t           food;
        logic                id_ok;
        logic                res_ok;
        logic                food_ok;
    } fd_cmd_t;

endpackage

//--- design/fd_input_capture.sv
`timescale 1ns/1ps
`include "fd_config.svh"

module fd_input_capture
    import fd_pkg::*;
(
    input  logic    clk,
    input  logic    inf,
    input  d_bus_u  d,
    input  logic    act_valid,
    input  logic    id_valid,
    input  logic    res_valid,
    input  logic    food_valid,
    input  logic    done,
    output fd_cmd_t cmd
);

    action_e             act_q;
    logic [`FD_ID_W-1:0] id_q;
    logic [`FD_ID_W-1:0] res_q;
    food_ser_t           food_q;
    logic                id_ok_q;
    logic                res_ok_q;
    logic                food_ok_q;

    // ==================================================
    // action and captured flags
    // ==================================================

    // all cleared together at the end of a command
    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            act_q     <= ACT_NONE;
            id_ok_q   <= 1'b0;
            res_ok_q  <= 1'b0;
            food_ok_q <= 1'b0;
        end else if (done) begin
            act_q     <= ACT_NONE;
            id_ok_q   <= 1'b0;
            res_ok_q  <= 1'b0;
            food_ok_q <= 1'b0;
        end else begin
            if (act_valid) begin
                act_q <= d.act.act;
            end
            if (id_valid) begin
                id_ok_q <= 1'b1;
            end
            if (res_valid) begin
                res_ok_q <= 1'b1;
            end
            if (food_valid) begin
                food_ok_q <= 1'b1;
            end
        end
    end

    // ==================================================
    // operands
    // ==================================================

    // each strobe picks its own view of the bus word
    always_ff @(posedge clk) begin
        if (id_valid) begin
            id_q <= d.id.val;
        end
        if (res_valid) begin
            res_q <= d.res.val;
        end
        if (food_valid) begin
            food_q <= d.food.food;
        end
    end

    assign cmd = '{
        act:     act_q,
        id:      id_q,
        res:     res_q,
        food:    food_q,
        id_ok:   id_ok_q,
        res_ok:  res_ok_q,
        food_ok: food_ok_q
    };

endmodule

//--- design/fd_control.sv
`timescale 1ns/1ps
`include "fd_config.svh"

module fd_control
    import fd_pkg::*;
(
    input  logic                  clk,
    input  logic                  inf,
    input  fd_cmd_t               cmd,
    input  err_e                  err,
    input  logic                  C_out_valid,
    output logic                  load,
    output logic                  commit,
    output logic                  done,
    output logic                  C_in_valid,
    output logic                  C_r_wb,
    output logic [`FD_ADDR_W-1:0] C_addr,
    output logic                  out_valid,
    output logic                  complete,
    output err_e                  err_msg
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_READ,
        S_WAIT_READ,
        S_CALC,
        S_WRITE,
        S_WAIT_WRITE,
        S_OUTPUT
    } state_e;

    state_e state;
    state_e state_nxt;
    logic   addr_ok;
    logic   complete_q;
    err_e   err_q;

    // address operand of each action
    always_comb begin
        case (cmd.act)
            ACT_ORDER:              addr_ok = cmd.res_ok;
            ACT_DELIVER, ACT_CANCEL: addr_ok = cmd.id_ok;
            default:                addr_ok = 1'b0;
        endcase
    end

    // ==================================================
    // transaction fsm
    // ==================================================

    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            state <= S_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            S_IDLE: begin
                if (cmd.act != ACT_NONE) begin
                    state_nxt = S_READ;
                end
            end
            S_READ: begin
                if (addr_ok) begin
                    state_nxt = S_WAIT_READ;
                end
            end
            S_WAIT_READ: begin
                if (C_out_valid) begin
                    state_nxt = S_CALC;
                end
            end
            // skip the write when the command fails
            S_CALC:       state_nxt = (err == ERR_NONE) ? S_WRITE : S_OUTPUT;
            S_WRITE:      state_nxt = S_WAIT_WRITE;
            S_WAIT_WRITE: begin
                if (C_out_valid) begin
                    state_nxt = S_OUTPUT;
                end
            end
            S_OUTPUT:     state_nxt = S_IDLE;
            default:      state_nxt = S_IDLE;
        endcase
    end

    // ==================================================
    // dram request
    // ==================================================

    assign C_in_valid = (state == S_READ && addr_ok) || (state == S_WRITE);
    assign C_r_wb     = (state != S_WRITE);
    assign C_addr     = (cmd.act == ACT_ORDER) ? cmd.res : cmd.id;

    assign load   = (state == S_WAIT_READ) && C_out_valid;
    assign commit = (state == S_CALC) && (err == ERR_NONE);

    // ==================================================
    // result
    // ==================================================

    // judged once in calc, shown in the output cycle
    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            complete_q <= 1'b0;
            err_q      <= ERR_NONE;
        end else if (state == S_CALC) begin
            complete_q <= (err == ERR_NONE);
            err_q      <= err;
        end
    end

    assign out_valid = (state == S_OUTPUT);
    assign done      = (state == S_OUTPUT);
    assign complete  = out_valid & complete_q;
    assign err_msg   = out_valid ? err_q : ERR_NONE;

endmodule

//--- design/fd_record_update.sv
`timescale 1ns/1ps
`include "fd_config.svh"

module fd_record_update
    import fd_pkg::*;
(
    input  logic                  clk,
    input  logic                  inf,
    input  fd_cmd_t               cmd,
    input  logic                  load,
    input  logic                  commit,
    input  logic [`FD_WORD_W-1:0] C_data_r,
    output err_e                  err,
    output logic [`FD_WORD_W-1:0] C_data_w,
    output logic [`FD_WORD_W-1:0] out_info,
    input  logic                  out_valid,
    input  logic                  complete
);

    dman_info_t           dman_q;
    res_info_t            res_q;
    dman_info_t           dman_nxt;
    res_info_t            res_nxt;
    logic                 occ1;
    logic                 occ2;
    logic                 res_hit1;
    logic                 res_hit2;
    logic                 hit1;
    logic                 hit2;
    logic [`FD_SER_W-1:0] room;
    logic [`FD_SER_W-1:0] ser_ext;

    // slots sit in dram with their bytes swapped
    function automatic logic [`FD_SLOT_W-1:0] swap_bytes(input logic [`FD_SLOT_W-1:0] w);
        return {w[7:0], w[15:8]};
    endfunction

    // ==================================================
    // record register
    // ==================================================

    always_ff @(posedge clk or negedge inf) begin
        if (!inf) begin
            dman_q <= '0;
            res_q  <= '0;
        end else if (load) begin
            dman_q.ctm_info2 <= swap_bytes(C_data_r[`FD_SLOT2_LSB +: `FD_SLOT_W]);
            dman_q.ctm_info1 <= swap_bytes(C_data_r[`FD_SLOT1_LSB +: `FD_SLOT_W]);
            res_q            <= C_data_r[`FD_RES_LSB +: $bits(res_info_t)];
        end else if (commit) begin
            dman_q <= dman_nxt;
            res_q  <= res_nxt;
        end
    end

    // slot matching for cancel
    assign occ1     = (dman_q.ctm_info1.status != ST_NONE);
    assign occ2     = (dman_q.ctm_info2.status != ST_NONE);
    assign res_hit1 = occ1 && (dman_q.ctm_info1.res_id == cmd.res);
    assign res_hit2 = occ2 && (dman_q.ctm_info2.res_id == cmd.res);
    assign hit1     = res_hit1 && (dman_q.ctm_info1.food_id == cmd.food.food_id);
    assign hit2     = res_hit2 && (dman_q.ctm_info2.food_id == cmd.food.food_id);

    // free capacity, wraps like the 8-bit counters
    assign room    = res_q.limit - res_q.stock[1] - res_q.stock[2] - res_q.stock[3];
    assign ser_ext = `FD_SER_W'(cmd.food.ser);

    // ==================================================
    // error check
    // ==================================================

    always_comb begin
        err = ERR_NONE;
        case (cmd.act)
            ACT_DELIVER: begin
                if (!occ1) begin
                    err = ERR_NO_CUSTOMERS;
                end
            end
            ACT_ORDER: begin
                if (room < ser_ext) begin
                    err = ERR_RES_BUSY;
                end
            end
            ACT_CANCEL: begin
                if (!occ1 && !occ2) begin
                    err = ERR_WRONG_CANCEL;
                end else if (!res_hit1 && !res_hit2) begin
                    err = ERR_WRONG_RES_ID;
                end else if (!hit1 && !hit2) begin
                    err = ERR_WRONG_FOOD_ID;
                end
            end
            default: err = ERR_NONE;
        endcase
    end

    // ==================================================
    // updated record
    // ==================================================

    always_comb begin
        dman_nxt = dman_q;
        res_nxt  = res_q;
        case (cmd.act)
            ACT_ORDER: begin
                if (cmd.food.food_id != FOOD_NONE) begin
                    res_nxt.stock[cmd.food.food_id] = res_q.stock[cmd.food.food_id] + ser_ext;
                end
            end
            ACT_DELIVER: begin
                dman_nxt.ctm_info1 = dman_q.ctm_info2;
                dman_nxt.ctm_info2 = '0;
            end
            ACT_CANCEL: begin
                if (occ1 && occ2) begin
                    if (hit1 && hit2) begin
                        dman_nxt = '0;
                    end else if (hit1) begin
                        // second customer moves up
                        dman_nxt.ctm_info1 = dman_q.ctm_info2;
                        dman_nxt.ctm_info2 = '0;
                    end else begin
                        dman_nxt.ctm_info2 = '0;
                    end
                end else begin
                    // a lone matching customer empties the whole queue
                    dman_nxt = '0;
                end
            end
            default: begin
                dman_nxt = dman_q;
            end
        endcase
    end

    assign C_data_w = {swap_bytes(dman_q.ctm_info2), swap_bytes(dman_q.ctm_info1), res_q};

    always_comb begin
        out_info = '0;
        if (out_valid && complete) begin
            case (cmd.act)
                ACT_ORDER:               out_info = {{$bits(dman_info_t){1'b0}}, res_q};
                ACT_DELIVER, ACT_CANCEL: out_info = {dman_q, {$bits(res_info_t){1'b0}}};
                default:                 out_info = '0;
            endcase
        end
    end

endmodule

//--- design/fd_top.sv
`timescale 1ns/1ps
`include "fd_config.svh"

module fd_top
    import fd_pkg::*;
(
    input  logic                  clk,
    input  logic                  inf,
    input  d_bus_u                d,
    input  logic                  act_valid,
    input  logic                  id_valid,
    input  logic                  res_valid,
    input  logic                  food_valid,
    output logic                  out_valid,
    output logic                  complete,
    output err_e                  err_msg,
    output logic [`FD_WORD_W-1:0] out_info,
    output logic                  C_in_valid,
    output logic                  C_r_wb,
    output logic [`FD_ADDR_W-1:0] C_addr,
    output logic [`FD_WORD_W-1:0] C_data_w,
    input  logic                  C_out_valid,
    input  logic [`FD_WORD_W-1:0] C_data_r
);

    fd_cmd_t cmd;
    err_e    err;
    logic    load;
    logic    commit;
    logic    done;

    fd_input_capture u_capture (
        .clk        (clk),
        .inf        (inf),
        .d          (d),
        .act_valid  (act_valid),
        .id_valid   (id_valid),
        .res_valid  (res_valid),
        .food_valid (food_valid),
        .done       (done),
        .cmd        (cmd)
    );

    fd_control u_control (
        .clk         (clk),
        .inf         (inf),
        .cmd         (cmd),
        .err         (err),
        .C_out_valid (C_out_valid),
        .load        (load),
        .commit      (commit),
        .done        (done),
        .C_in_valid  (C_in_valid),
        .C_r_wb      (C_r_wb),
        .C_addr      (C_addr),
        .out_valid   (out_valid),
        .complete    (complete),
        .err_msg     (err_msg)
    );

    fd_record_update u_record (
        .clk       (clk),
        .inf       (inf),
        .cmd       (cmd),
        .load      (load),
        .commit    (commit),
        .C_data_r  (C_data_r),
        .err       (err),
        .C_data_w  (C_data_w),
        .out_info  (out_info),
        .out_valid (out_valid),
        .complete  (complete)
    );

endmodule

//--- bench/fd_clock_gen.sv
`timescale 1ns/1ps

module fd_clock_gen (
    output logic clk,
    output logic inf
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset held low for the first 4 rising edges
    initial begin
        inf = 1'b0;
        repeat (4) @(posedge clk);
        inf <= 1'b1;
    end

endmodule

//--- bench/fd_dram_model.sv
`timescale 1ns/1ps
`include "fd_config.svh"

module fd_dram_model
    import fd_pkg::*;
(
    input  logic                  clk,
    input  logic                  inf,
    input  logic                  C_in_valid,
    input  logic                  C_r_wb,
    input  logic [`FD_ADDR_W-1:0] C_addr,
    input  logic [`FD_WORD_W-1:0] C_data_w,
    output logic                  C_out_valid,
    output logic [`FD_WORD_W-1:0] C_data_r
);

    logic [`FD_WORD_W-1:0] mem [0:(1<<`FD_ADDR_W)-1];
    integer                seed;

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    // a slot sits in memory with its bytes swapped
    function automatic logic [`FD_SLOT_W-1:0] stored_slot(input ctm_info_t c);
        return {c[7:0], c[15:8]};
    endfunction

    initial begin
        ctm_info_t             c1;
        ctm_info_t             c2;
        res_info_t             r;
        logic [`FD_ADDR_W-1:0] pend_addr;
        logic                  pend_rd;
        logic                  busy;
        integer                wait_cnt;
        seed = 32'h22ad3954;

        // ==================================================
        // random image, small restaurant ids so cancels can hit
        // ==================================================
        for (int a = 0; a < (1 << `FD_ADDR_W); a++) begin
            c1.status  = status_e'(2'(rand_below(3)));
            c1.res_id  = 8'(rand_below(8));
            c1.food_id = food_e'(2'(rand_below(4)));
            c1.ser     = 4'(rand_below(16));
            c2.status  = status_e'(2'(rand_below(3)));
            c2.res_id  = 8'(rand_below(8));
            c2.food_id = food_e'(2'(rand_below(4)));
            c2.ser     = 4'(rand_below(16));
            r.stock[1] = 8'(rand_below(64));
            r.stock[2] = 8'(rand_below(64));
            r.stock[3] = 8'(rand_below(64));
            r.limit    = 8'(rand_below(256));
            mem[`FD_ADDR_W'(a)] = {stored_slot(c2), stored_slot(c1), r};
        end

        C_out_valid <= 1'b0;
        C_data_r    <= '0;
        busy      = 1'b0;
        pend_rd   = 1'b1;
        pend_addr = '0;
        wait_cnt  = 0;

        // ==================================================
        // one request at a time, answered after 1 to 6 cycles
        // ==================================================
        forever begin
            @(posedge clk);
            C_out_valid <= 1'b0;
            if (!inf) begin
                busy = 1'b0;
            end else if (busy) begin
                if (wait_cnt <= 1) begin
                    C_out_valid <= 1'b1;
                    if (pend_rd) begin
                        C_data_r <= mem[pend_addr];
                    end
                    busy = 1'b0;
                end else begin
                    wait_cnt = wait_cnt - 1;
                end
            end else if (C_in_valid) begin
                busy      = 1'b1;
                pend_addr = C_addr;
                pend_rd   = C_r_wb;
                wait_cnt  = 1 + rand_below(6);
                // write data lands at request time
                if (!C_r_wb) begin
                    mem[C_addr] = C_data_w;
                end
            end
        end
    end

endmodule

//--- bench/fd_tb.sv
`timescale 1ns/1ps
`include "fd_config.svh"

module fd_tb
    import fd_pkg::*;
();

    localparam int N_CMD      = 300;
    localparam int CMD_CYCLES = 60;
    localparam int CLK_NS     = 20;

    localparam int OP_ACT  = 0;
    localparam int OP_ID   = 1;
    localparam int OP_RES  = 2;
    localparam int OP_FOOD = 3;

    logic                  clk;
    logic                  inf;
    d_bus_u                d;
    logic                  act_valid;
    logic                  id_valid;
    logic                  res_valid;
    logic                  food_valid;
    logic                  out_valid;
    logic                  complete;
    err_e                  err_msg;
    logic [`FD_WORD_W-1:0] out_info;
    logic                  C_in_valid;
    logic                  C_r_wb;
    logic [`FD_ADDR_W-1:0] C_addr;
    logic [`FD_WORD_W-1:0] C_data_w;
    logic                  C_out_valid;
    logic [`FD_WORD_W-1:0] C_data_r;

    // reference copy of the dram
    logic [`FD_WORD_W-1:0] img [0:(1<<`FD_ADDR_W)-1];
    integer                seed;
    int                    errors = 0;
    int                    mon_errors = 0;
    int                    checks = 0;
    int                    pulses = 0;
    logic                  ov_q = 1'b0;

    fd_clock_gen clkgen (
        .clk (clk),
        .inf (inf)
    );

    fd_dram_model dram (
        .clk         (clk),
        .inf         (inf),
        .C_in_valid  (C_in_valid),
        .C_r_wb      (C_r_wb),
        .C_addr      (C_addr),
        .C_data_w    (C_data_w),
        .C_out_valid (C_out_valid),
        .C_data_r    (C_data_r)
    );

    fd_top uut (
        .clk         (clk),
        .inf         (inf),
        .d           (d),
        .act_valid   (act_valid),
        .id_valid    (id_valid),
        .res_valid   (res_valid),
        .food_valid  (food_valid),
        .out_valid   (out_valid),
        .complete    (complete),
        .err_msg     (err_msg),
        .out_info    (out_info),
        .C_in_valid  (C_in_valid),
        .C_r_wb      (C_r_wb),
        .C_addr      (C_addr),
        .C_data_w    (C_data_w),
        .C_out_valid (C_out_valid),
        .C_data_r    (C_data_r)
    );

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic clear_strobes();
        act_valid  <= 1'b0;
        id_valid   <= 1'b0;
        res_valid  <= 1'b0;
        food_valid <= 1'b0;
    endtask

    // zero to three idle cycles, then a one-cycle strobe
    task automatic send_operand(input int kind, input logic [15:0] w);
        int gap;
        gap = rand_below(4);
        clear_strobes();
        repeat (gap) @(posedge clk);
        d <= w;
        case (kind)
            OP_ACT:  act_valid <= 1'b1;
            OP_ID:   id_valid <= 1'b1;
            OP_RES:  res_valid <= 1'b1;
            default: food_valid <= 1'b1;
        endcase
        @(posedge clk);
    endtask

    // ==================================================
    // reference model
    // ==================================================

    task automatic predict(input action_e act, input logic [7:0] addr, input logic [7:0] rid,
                           input food_e fid, input logic [5:0] ser,
                           output err_e e, output logic [`FD_WORD_W-1:0] info);
        logic [`FD_WORD_W-1:0] w;
        ctm_info_t             c1;
        ctm_info_t             c2;
        logic [7:0]            s1;
        logic [7:0]            s2;
        logic [7:0]            s3;
        logic [7:0]            lim;
        logic                  occ1;
        logic                  occ2;
        logic                  m1;
        logic                  m2;
        w   = img[addr];
        c2  = {w[55:48], w[63:56]};
        c1  = {w[39:32], w[47:40]};
        s3  = w[31:24];
        s2  = w[23:16];
        s1  = w[15:8];
        lim = w[7:0];
        e    = ERR_NONE;
        info = '0;
        occ1 = (c1.status != ST_NONE);
        occ2 = (c2.status != ST_NONE);
        case (act)
            ACT_ORDER: begin
                if (8'(lim - s1 - s2 - s3) < {2'b00, ser}) begin
                    e = ERR_RES_BUSY;
                end else begin
                    if (fid == FOOD1) s1 = s1 + {2'b00, ser};
                    if (fid == FOOD2) s2 = s2 + {2'b00, ser};
                    if (fid == FOOD3) s3 = s3 + {2'b00, ser};
                    info = {32'b0, s3, s2, s1, lim};
                end
            end
            ACT_DELIVER: begin
                if (!occ1) begin
                    e = ERR_NO_CUSTOMERS;
                end else begin
                    c1 = c2;
                    c2 = '0;
                end
            end
            default: begin
                m1 = occ1 && c1.res_id == rid && c1.food_id == fid;
                m2 = occ2 && c2.res_id == rid && c2.food_id == fid;
                if (!occ1 && !occ2) begin
                    e = ERR_WRONG_CANCEL;
                end else if (!(occ1 && c1.res_id == rid) && !(occ2 && c2.res_id == rid)) begin
                    e = ERR_WRONG_RES_ID;
                end else if (!m1 && !m2) begin
                    e = ERR_WRONG_FOOD_ID;
                end else if (occ1 && occ2 && m1 && !m2) begin
                    c1 = c2;
                    c2 = '0;
                end else if (occ1 && occ2 && !m1) begin
                    c2 = '0;
                end else begin
                    c1 = '0;
                    c2 = '0;
                end
            end
        endcase
        if (e == ERR_NONE && act != ACT_ORDER) begin
            info = {c2, c1, 32'b0};
        end
        if (e == ERR_NONE) begin
            img[addr] = {c2[7:0], c2[15:8], c1[7:0], c1[15:8], s3, s2, s1, lim};
        end
    endtask

    // ==================================================
    // one command end to end
    // ==================================================

    task automatic run_command(input int n);
        action_e               act;
        logic [7:0]            addr;
        logic [7:0]            rid;
        food_e                 fid;
        logic [5:0]            ser;
        ctm_info_t             pick;
        err_e                  exp_err;
        logic [`FD_WORD_W-1:0] exp_info;
        logic [`FD_WORD_W-1:0] w;
        act  = action_e'(3'(1 + rand_below(3)));
        addr = 8'(rand_below(64));
        fid  = food_e'(2'(1 + rand_below(3)));
        ser  = 6'(rand_below(64));
        rid  = 8'(rand_below(8));
        // half the cancels aim at a queued customer
        if (act == ACT_CANCEL && rand_below(2) == 0) begin
            w    = img[addr];
            pick = (rand_below(2) == 0) ? {w[39:32], w[47:40]} : {w[55:48], w[63:56]};
            rid  = pick.res_id;
            if (rand_below(4) != 0) begin
                fid = pick.food_id;
            end
        end
        if (act == ACT_ORDER) begin
            rid = addr;
        end
        predict(act, addr, rid, fid, ser, exp_err, exp_info);

        send_operand(OP_ACT, {13'b0, act});
        case (act)
            ACT_ORDER: begin
                send_operand(OP_FOOD, {8'b0, fid, ser});
                send_operand(OP_RES, {8'b0, addr});
            end
            ACT_DELIVER: send_operand(OP_ID, {8'b0, addr});
            default: begin
                send_operand(OP_RES, {8'b0, rid});
                send_operand(OP_FOOD, {8'b0, fid, ser});
                send_operand(OP_ID, {8'b0, addr});
            end
        endcase
        clear_strobes();
        while (out_valid !== 1'b1) @(posedge clk);

        if (err_msg != exp_err) begin
            errors++;
            $display("ERR %0t: cmd %0d %s err_msg %0d, expected %0d",
                     $time, n, act.name(), err_msg, exp_err);
        end
        if (complete != (exp_err == ERR_NONE)) begin
            errors++;
            $display("ERR %0t: cmd %0d %s complete %0b", $time, n, act.name(), complete);
        end
        if (out_info != exp_info) begin
            errors++;
            $display("ERR %0t: cmd %0d %s out_info %h, expected %h",
                     $time, n, act.name(), out_info, exp_info);
        end
        if (dram.mem[addr] != img[addr]) begin
            errors++;
            $display("ERR %0t: cmd %0d dram[%0d] %h, expected %h",
                     $time, n, addr, dram.mem[addr], img[addr]);
        end
        checks += 4;
    endtask

    // result fields stay zero outside the pulse
    always @(posedge clk) begin
        if (inf) begin
            if (out_valid && ov_q) begin
                mon_errors++;
                $display("ERR %0t: out_valid high for more than one cycle", $time);
            end
            if (!out_valid && (complete || err_msg != ERR_NONE || out_info != '0)) begin
                mon_errors++;
                $display("ERR %0t: result fields not zero while out_valid is low", $time);
            end
            if (out_valid) begin
                pulses++;
            end
        end
        ov_q = out_valid;
    end

    // ==================================================
    // main sequence
    // ==================================================

    initial begin
        seed = 32'h22ad3954;
        d <= '0;
        clear_strobes();
        @(posedge clk);
        while (inf !== 1'b1) @(posedge clk);

        if (out_valid || complete || C_in_valid || err_msg != ERR_NONE || !C_r_wb) begin
            errors++;
            $display("ERR %0t: outputs not idle after reset", $time);
        end
        checks++;
        for (int a = 0; a < (1 << `FD_ADDR_W); a++) begin
            img[`FD_ADDR_W'(a)] = dram.mem[`FD_ADDR_W'(a)];
        end

        for (int n = 0; n < N_CMD; n++) begin
            run_command(n);
        end
        repeat (3) @(posedge clk);

        if (pulses != N_CMD) begin
            errors++;
            $display("ERR %0t: %0d out_valid pulses for %0d commands", $time, pulses, N_CMD);
        end
        for (int a = 0; a < (1 << `FD_ADDR_W); a++) begin
            if (dram.mem[`FD_ADDR_W'(a)] != img[`FD_ADDR_W'(a)]) begin
                errors++;
                $display("ERR %0t: final dram[%0d] %h, expected %h",
                         $time, a, dram.mem[`FD_ADDR_W'(a)], img[`FD_ADDR_W'(a)]);
            end
        end
        checks += 1 + (1 << `FD_ADDR_W);

        $display("summary: %0d commands, %0d checks, %0d errors",
                 N_CMD, checks, errors + mon_errors);
        if (errors + mon_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // watchdog sized for the longest command
    initial begin
        #(N_CMD * CMD_CYCLES * CLK_NS);
        $display("run timed out before all %0d commands finished", N_CMD);
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

//--- sim.f
+incdir+design
design/fd_pkg.sv
design/fd_input_capture.sv
design/fd_control.sv
design/fd_record_update.sv
design/fd_top.sv
bench/fd_clock_gen.sv
bench/fd_dram_model.sv
bench/fd_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, pass only on the pass message

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f sim.f --top-module fd_tb -o fd_sim \
    && ./obj_dir/fd_sim | tee /dev/stderr | grep -q -F '*** TEST PASSED ***' \
    && { echo "run_sim: simulation passed"; exit 0; } \
    || { echo "run_sim: simulation failed"; exit 1; }
